// File: hw/io_bedrock_defs.svh
// width macros for the uncached IO path, included by the package and every RTL file
`ifndef IO_BEDROCK_DEFS_SVH
`define IO_BEDROCK_DEFS_SVH

// physical address bits carried in every header
`define IO_PADDR_WIDTH 16

// agent identifiers
`define IO_LCE_ID_WIDTH 4
`define IO_CCE_ID_WIDTH 4

// domain id stamped on forward messages
`define IO_DID_WIDTH 3

// one beat per message
`define IO_DATA_WIDTH 64

// size code n means 2**n bytes, so 1 to 8 bytes
`define IO_SIZE_WIDTH 2

// endpoint register bank depth, in 64-bit words
`define IO_REG_WORDS 16

`endif

// File: hw/io_bedrock_pkg.sv
// message types and header layouts shared by the LCE and IO channels of the uncached path
`include "io_bedrock_defs.svh"

package io_bedrock_pkg;

  // LCE request kinds
  typedef enum logic [0:0] {
    e_bedrock_req_uc_rd = 1'b0,
    e_bedrock_req_uc_wr = 1'b1
  } lce_req_type_e;

  // LCE command kinds sent back to the cache side
  typedef enum logic [0:0] {
    e_bedrock_cmd_uc_data    = 1'b0,
    e_bedrock_cmd_uc_st_done = 1'b1
  } lce_cmd_type_e;

  // used by both forward and reverse IO headers
  typedef enum logic [0:0] {
    e_bedrock_mem_uc_rd = 1'b0,
    e_bedrock_mem_uc_wr = 1'b1
  } mem_msg_type_e;

  typedef struct packed {
    lce_req_type_e                msg_type;
    logic [`IO_PADDR_WIDTH-1:0]   addr;
    logic [`IO_SIZE_WIDTH-1:0]    size;
    logic [`IO_LCE_ID_WIDTH-1:0]  src_id;
  } lce_req_header_s;

  // src_id here is the CCE that answers
  typedef struct packed {
    lce_cmd_type_e                msg_type;
    logic [`IO_PADDR_WIDTH-1:0]   addr;
    logic [`IO_SIZE_WIDTH-1:0]    size;
    logic [`IO_LCE_ID_WIDTH-1:0]  dst_id;
    logic [`IO_CCE_ID_WIDTH-1:0]  src_id;
  } lce_cmd_header_s;

  typedef struct packed {
    mem_msg_type_e                msg_type;
    logic [`IO_PADDR_WIDTH-1:0]   addr;
    logic [`IO_SIZE_WIDTH-1:0]    size;
    logic [`IO_LCE_ID_WIDTH-1:0]  lce_id;
    logic [`IO_DID_WIDTH-1:0]     did;
    logic                         uncached;
  } mem_fwd_header_s;

  // same layout as the forward header, echoed by the endpoint
  typedef struct packed {
    mem_msg_type_e                msg_type;
    logic [`IO_PADDR_WIDTH-1:0]   addr;
    logic [`IO_SIZE_WIDTH-1:0]    size;
    logic [`IO_LCE_ID_WIDTH-1:0]  lce_id;
    logic [`IO_DID_WIDTH-1:0]     did;
    logic                         uncached;
  } mem_rev_header_s;

endpackage

// File: hw/io_msg_fifo.sv
// two-entry ready/valid message queue whose header type is set per instance
`timescale 1ns/1ps
`include "io_bedrock_defs.svh"

module io_msg_fifo #(
  parameter type payload_t = logic [7:0]
) (
  input                               clk_i
  , input                             arst_n_i

  // write side
  , input  payload_t                  header_i
  , input        [`IO_DATA_WIDTH-1:0] data_i
  , input                             v_i
  , output logic                      ready_and_o

  // read side
  , output payload_t                  header_o
  , output logic [`IO_DATA_WIDTH-1:0] data_o
  , output logic                      v_o
  , input                             ready_and_i
);

  payload_t                  header_mem [2];
  logic [`IO_DATA_WIDTH-1:0] data_mem   [2];

  logic       wr_ptr;
  logic       rd_ptr;
  logic [1:0] count;
  logic       wr_fire;
  logic       rd_fire;

  // full refuses writes even when a read happens the same cycle
  assign ready_and_o = (count != 2'd2);
  assign v_o         = (count != 2'd0);
  assign wr_fire     = v_i & ready_and_o;
  assign rd_fire     = v_o & ready_and_i;

  assign header_o = header_mem[rd_ptr];
  assign data_o   = data_mem[rd_ptr];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (wr_fire) begin
        wr_ptr <= ~wr_ptr;
      end
      if (rd_fire) begin
        rd_ptr <= ~rd_ptr;
      end
      case ({wr_fire, rd_fire})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (wr_fire) begin
      header_mem[wr_ptr] <= header_i;
      data_mem[wr_ptr]   <= data_i;
    end
  end

  // an unread head entry is never overwritten by a write into a full queue
  a_head_kept: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (v_o && !ready_and_i) |=> (v_o && $stable(header_o) && $stable(data_o)));

endmodule

// File: hw/io_reg_endpoint.sv
// IO endpoint that answers uncached reads and writes from a bank of 64-bit registers
`timescale 1ns/1ps
`include "io_bedrock_defs.svh"

module io_reg_endpoint (
  input                                      clk_i
  , input                                    arst_n_i

  // forward messages in
  , input  io_bedrock_pkg::mem_fwd_header_s  fwd_header_i
  , input        [`IO_DATA_WIDTH-1:0]        fwd_data_i
  , input                                    fwd_v_i
  , output logic                             fwd_ready_and_o

  // reverse messages out
  , output io_bedrock_pkg::mem_rev_header_s  rev_header_o
  , output logic [`IO_DATA_WIDTH-1:0]        rev_data_o
  , output logic                             rev_v_o
  , input                                    rev_ready_and_i
);

  localparam int IDX_W = $clog2(`IO_REG_WORDS);

  logic [`IO_DATA_WIDTH-1:0] regs_q [`IO_REG_WORDS];

  logic [IDX_W-1:0]          idx;
  logic [2:0]                offset;
  logic                      is_wr;
  logic                      fwd_fire;
  logic                      rev_fire;
  logic [7:0]                byte_en;
  logic [`IO_DATA_WIDTH-1:0] size_mask;
  logic [`IO_DATA_WIDTH-1:0] wr_shifted;
  logic [`IO_DATA_WIDTH-1:0] rd_word;

  // word select and byte lane inside the word
  assign idx    = fwd_header_i.addr[3 +: IDX_W];
  assign offset = fwd_header_i.addr[2:0];
  assign is_wr  = (fwd_header_i.msg_type == io_bedrock_pkg::e_bedrock_mem_uc_wr);

  // take a new message when the response slot is free or leaving now
  assign fwd_ready_and_o = ~rev_v_o | rev_ready_and_i;
  assign fwd_fire        = fwd_v_i & fwd_ready_and_o;
  assign rev_fire        = rev_v_o & rev_ready_and_i;

  always_comb begin
    case (fwd_header_i.size)
      2'd0:    size_mask = 64'h0000_0000_0000_00ff;
      2'd1:    size_mask = 64'h0000_0000_0000_ffff;
      2'd2:    size_mask = 64'h0000_0000_ffff_ffff;
      default: size_mask = '1;
    endcase
    // low bytes of the data land at the addressed lanes
    byte_en    = 8'((8'h01 << (4'd1 << fwd_header_i.size)) - 8'h01) << offset;
    wr_shifted = fwd_data_i << {offset, 3'b000};
    rd_word    = (regs_q[idx] >> {offset, 3'b000}) & size_mask;
  end

  // register bank
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int w = 0; w < `IO_REG_WORDS; w++) begin
        regs_q[w] <= '0;
      end
    end else if (fwd_fire && is_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (byte_en[b]) begin
          regs_q[idx][b*8 +: 8] <= wr_shifted[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rev_v_o <= 1'b0;
    end else if (fwd_fire) begin
      rev_v_o <= 1'b1;
    end else if (rev_fire) begin
      rev_v_o <= 1'b0;
    end
  end

  // response payload, header echoes the request
  always_ff @(posedge clk_i) begin
    if (fwd_fire) begin
      rev_header_o.msg_type <= fwd_header_i.msg_type;
      rev_header_o.addr     <= fwd_header_i.addr;
      rev_header_o.size     <= fwd_header_i.size;
      rev_header_o.lce_id   <= fwd_header_i.lce_id;
      rev_header_o.did      <= fwd_header_i.did;
      rev_header_o.uncached <= fwd_header_i.uncached;
      rev_data_o            <= is_wr ? '0 : rd_word;
    end
  end

  // response must not change while rev_q pushes back
  a_rev_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (rev_v_o && !rev_ready_and_i) |=>
      (rev_v_o && $stable(rev_header_o) && $stable(rev_data_o)));

endmodule

// File: hw/io_cce.sv
// IO CCE: turns LCE uncached requests into IO forward messages and IO responses into LCE commands
`timescale 1ns/1ps
`include "io_bedrock_defs.svh"

module io_cce (
  input                                      clk_i
  , input                                    arst_n_i

  , input        [`IO_DID_WIDTH-1:0]         did_i
  , input        [`IO_CCE_ID_WIDTH-1:0]      cce_id_i

  // LCE side, ready/valid
  , input  io_bedrock_pkg::lce_req_header_s  lce_req_header_i
  , input        [`IO_DATA_WIDTH-1:0]        lce_req_data_i
  , input                                    lce_req_v_i
  , output logic                             lce_req_ready_and_o

  , output io_bedrock_pkg::lce_cmd_header_s  lce_cmd_header_o
  , output logic [`IO_DATA_WIDTH-1:0]        lce_cmd_data_o
  , output logic                             lce_cmd_v_o
  , input                                    lce_cmd_ready_and_i

  // IO side, ready/valid
  , input  io_bedrock_pkg::mem_rev_header_s  io_rev_header_i
  , input        [`IO_DATA_WIDTH-1:0]        io_rev_data_i
  , input                                    io_rev_v_i
  , output logic                             io_rev_ready_and_o

  , output io_bedrock_pkg::mem_fwd_header_s  io_fwd_header_o
  , output logic [`IO_DATA_WIDTH-1:0]        io_fwd_data_o
  , output logic                             io_fwd_v_o
  , input                                    io_fwd_ready_and_i
);

  logic req_is_wr;
  logic rev_is_wr;

  assign req_is_wr = (lce_req_header_i.msg_type == io_bedrock_pkg::e_bedrock_req_uc_wr);
  assign rev_is_wr = (io_rev_header_i.msg_type == io_bedrock_pkg::e_bedrock_mem_uc_wr);

  // request to forward message
  always_comb begin
    io_fwd_header_o          = '0;
    io_fwd_header_o.msg_type = req_is_wr ? io_bedrock_pkg::e_bedrock_mem_uc_wr
                                         : io_bedrock_pkg::e_bedrock_mem_uc_rd;
    io_fwd_header_o.addr     = lce_req_header_i.addr;
    io_fwd_header_o.size     = lce_req_header_i.size;
    io_fwd_header_o.lce_id   = lce_req_header_i.src_id;
    io_fwd_header_o.did      = did_i;
    io_fwd_header_o.uncached = 1'b1;
    io_fwd_data_o            = lce_req_data_i;
    io_fwd_v_o               = lce_req_v_i;
    lce_req_ready_and_o      = io_fwd_ready_and_i;
  end

  // reverse message to LCE command
  always_comb begin
    lce_cmd_header_o          = '0;
    lce_cmd_header_o.msg_type = rev_is_wr ? io_bedrock_pkg::e_bedrock_cmd_uc_st_done
                                          : io_bedrock_pkg::e_bedrock_cmd_uc_data;
    lce_cmd_header_o.addr     = io_rev_header_i.addr;
    lce_cmd_header_o.size     = io_rev_header_i.size;
    lce_cmd_header_o.dst_id   = io_rev_header_i.lce_id;
    lce_cmd_header_o.src_id   = cce_id_i;
    lce_cmd_data_o            = io_rev_data_i;
    lce_cmd_v_o               = io_rev_v_i;
    io_rev_ready_and_o        = lce_cmd_ready_and_i;
  end

  // a stalled request must not be withdrawn by the LCE
  a_req_held: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (lce_req_v_i && !lce_req_ready_and_o) |=> lce_req_v_i);

endmodule

// File: hw/io_subsystem_top.sv
// top of the uncached IO path: IO CCE, forward and reverse queues, register endpoint
`timescale 1ns/1ps
`include "io_bedrock_defs.svh"

module io_subsystem_top (
  input                                      clk_i
  , input                                    arst_n_i

  // held steady after reset
  , input        [`IO_DID_WIDTH-1:0]         did_i
  , input        [`IO_CCE_ID_WIDTH-1:0]      cce_id_i

  // LCE request channel
  , input  io_bedrock_pkg::lce_req_header_s  lce_req_header_i
  , input        [`IO_DATA_WIDTH-1:0]        lce_req_data_i
  , input                                    lce_req_v_i
  , output logic                             lce_req_ready_and_o

  // LCE command channel
  , output io_bedrock_pkg::lce_cmd_header_s  lce_cmd_header_o
  , output logic [`IO_DATA_WIDTH-1:0]        lce_cmd_data_o
  , output logic                             lce_cmd_v_o
  , input                                    lce_cmd_ready_and_i
);

  // io_cce to fwd_q
  io_bedrock_pkg::mem_fwd_header_s fwd_header;
  logic [`IO_DATA_WIDTH-1:0]       fwd_data;
  logic                            fwd_v;
  logic                            fwd_ready;

  // fwd_q to endpoint
  io_bedrock_pkg::mem_fwd_header_s q_fwd_header;
  logic [`IO_DATA_WIDTH-1:0]       q_fwd_data;
  logic                            q_fwd_v;
  logic                            q_fwd_ready;

  // endpoint to rev_q
  io_bedrock_pkg::mem_rev_header_s rev_header;
  logic [`IO_DATA_WIDTH-1:0]       rev_data;
  logic                            rev_v;
  logic                            rev_ready;

  // rev_q back to io_cce
  io_bedrock_pkg::mem_rev_header_s q_rev_header;
  logic [`IO_DATA_WIDTH-1:0]       q_rev_data;
  logic                            q_rev_v;
  logic                            q_rev_ready;

  io_cce u_io_cce (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .did_i               (did_i),
    .cce_id_i            (cce_id_i),
    .lce_req_header_i    (lce_req_header_i),
    .lce_req_data_i      (lce_req_data_i),
    .lce_req_v_i         (lce_req_v_i),
    .lce_req_ready_and_o (lce_req_ready_and_o),
    .lce_cmd_header_o    (lce_cmd_header_o),
    .lce_cmd_data_o      (lce_cmd_data_o),
    .lce_cmd_v_o         (lce_cmd_v_o),
    .lce_cmd_ready_and_i (lce_cmd_ready_and_i),
    .io_rev_header_i     (q_rev_header),
    .io_rev_data_i       (q_rev_data),
    .io_rev_v_i          (q_rev_v),
    .io_rev_ready_and_o  (q_rev_ready),
    .io_fwd_header_o     (fwd_header),
    .io_fwd_data_o       (fwd_data),
    .io_fwd_v_o          (fwd_v),
    .io_fwd_ready_and_i  (fwd_ready)
  );

  io_msg_fifo #(.payload_t(io_bedrock_pkg::mem_fwd_header_s)) fwd_q (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .header_i    (fwd_header),
    .data_i      (fwd_data),
    .v_i         (fwd_v),
    .ready_and_o (fwd_ready),
    .header_o    (q_fwd_header),
    .data_o      (q_fwd_data),
    .v_o         (q_fwd_v),
    .ready_and_i (q_fwd_ready)
  );

  io_reg_endpoint u_io_reg_endpoint (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .fwd_header_i    (q_fwd_header),
    .fwd_data_i      (q_fwd_data),
    .fwd_v_i         (q_fwd_v),
    .fwd_ready_and_o (q_fwd_ready),
    .rev_header_o    (rev_header),
    .rev_data_o      (rev_data),
    .rev_v_o         (rev_v),
    .rev_ready_and_i (rev_ready)
  );

  io_msg_fifo #(.payload_t(io_bedrock_pkg::mem_rev_header_s)) rev_q (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .header_i    (rev_header),
    .data_i      (rev_data),
    .v_i         (rev_v),
    .ready_and_o (rev_ready),
    .header_o    (q_rev_header),
    .data_o      (q_rev_data),
    .v_o         (q_rev_v),
    .ready_and_i (q_rev_ready)
  );

endmodule

// File: verification/tb_io_subsystem.sv
// self-checking testbench for the uncached IO path, random loads and stores against a register model
`timescale 1ns/1ps
`include "io_bedrock_defs.svh"

module tb_io_subsystem;

  localparam int N_REQ         = 400;
  localparam int CYC_PER_REQ   = 40;
  localparam int CLK_PERIOD_NS = 4;
  localparam logic [`IO_DID_WIDTH-1:0]    DID    = 3'd5;
  localparam logic [`IO_CCE_ID_WIDTH-1:0] CCE_ID = 4'd9;

  logic                            clk_i;
  logic                            arst_n_i;
  logic [`IO_DID_WIDTH-1:0]        did_i;
  logic [`IO_CCE_ID_WIDTH-1:0]     cce_id_i;
  io_bedrock_pkg::lce_req_header_s lce_req_header_i;
  logic [`IO_DATA_WIDTH-1:0]       lce_req_data_i;
  logic                            lce_req_v_i;
  logic                            lce_req_ready_and_o;
  io_bedrock_pkg::lce_cmd_header_s lce_cmd_header_o;
  logic [`IO_DATA_WIDTH-1:0]       lce_cmd_data_o;
  logic                            lce_cmd_v_o;
  logic                            lce_cmd_ready_and_i;

  integer seed;
  int     accepted_count;
  int     rcvd_count;

  // reference copy of the endpoint registers and the commands still owed
  logic [`IO_DATA_WIDTH-1:0]       model_regs [`IO_REG_WORDS];
  io_bedrock_pkg::lce_cmd_header_s exp_hdr_q  [$];
  logic [`IO_DATA_WIDTH-1:0]       exp_data_q [$];

  io_subsystem_top UUT (
    .clk_i               (clk_i),
    .arst_n_i            (arst_n_i),
    .did_i               (did_i),
    .cce_id_i            (cce_id_i),
    .lce_req_header_i    (lce_req_header_i),
    .lce_req_data_i      (lce_req_data_i),
    .lce_req_v_i         (lce_req_v_i),
    .lce_req_ready_and_o (lce_req_ready_and_o),
    .lce_cmd_header_o    (lce_cmd_header_o),
    .lce_cmd_data_o      (lce_cmd_data_o),
    .lce_cmd_v_o         (lce_cmd_v_o),
    .lce_cmd_ready_and_i (lce_cmd_ready_and_i)
  );

  always #(CLK_PERIOD_NS / 2) clk_i = ~clk_i;

  task automatic fail_run(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_cmd_header(input io_bedrock_pkg::lce_cmd_header_s got,
                                  input io_bedrock_pkg::lce_cmd_header_s exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: lce_cmd_header_o got %h expected %h", got, exp));
    end
  endtask

  task automatic check_cmd_data(input logic [`IO_DATA_WIDTH-1:0] got,
                                input logic [`IO_DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("Error: lce_cmd_data_o got %h expected %h", got, exp));
    end
  endtask

  // advance one clock, then drive the command ready, low about 30% of cycles
  task automatic next_cycle();
    logic [31:0] rnd;
    @(posedge clk_i);
    #1;
    rnd = $random(seed);
    lce_cmd_ready_and_i = (rnd % 100) >= 30;
  endtask

  task automatic make_request(output io_bedrock_pkg::lce_req_header_s hdr,
                              output logic [`IO_DATA_WIDTH-1:0] data);
    logic [31:0] rnd;
    logic [2:0]  off;
    rnd = $random(seed);
    hdr = '0;
    hdr.msg_type = rnd[0] ? io_bedrock_pkg::e_bedrock_req_uc_wr
                          : io_bedrock_pkg::e_bedrock_req_uc_rd;
    hdr.size = rnd[2:1];
    // offset aligned down to the access size
    off = rnd[5:3] & (3'h7 << rnd[2:1]);
    // upper bits are random so the 128-byte window wraps
    hdr.addr   = {rnd[14:6], rnd[18:15], off};
    hdr.src_id = rnd[22:19];
    data = {$random(seed), $random(seed)};
  endtask

  // expected command for an accepted request, built byte by byte
  task automatic model_accept(input io_bedrock_pkg::lce_req_header_s hdr,
                              input logic [`IO_DATA_WIDTH-1:0] data);
    io_bedrock_pkg::lce_cmd_header_s exp_hdr;
    logic [`IO_DATA_WIDTH-1:0]       exp_data;
    logic [3:0]                      idx;
    int                              off;
    int                              nbytes;
    idx    = hdr.addr[6:3];
    off    = int'(hdr.addr[2:0]);
    nbytes = 1 << hdr.size;
    exp_hdr        = '0;
    exp_hdr.addr   = hdr.addr;
    exp_hdr.size   = hdr.size;
    exp_hdr.dst_id = hdr.src_id;
    exp_hdr.src_id = CCE_ID;
    exp_data       = '0;
    if (hdr.msg_type == io_bedrock_pkg::e_bedrock_req_uc_wr) begin
      exp_hdr.msg_type = io_bedrock_pkg::e_bedrock_cmd_uc_st_done;
      for (int b = 0; b < nbytes; b++) begin
        model_regs[idx][(off + b) * 8 +: 8] = data[b * 8 +: 8];
      end
    end else begin
      exp_hdr.msg_type = io_bedrock_pkg::e_bedrock_cmd_uc_data;
      for (int b = 0; b < nbytes; b++) begin
        exp_data[b * 8 +: 8] = model_regs[idx][(off + b) * 8 +: 8];
      end
    end
    exp_hdr_q.push_back(exp_hdr);
    exp_data_q.push_back(exp_data);
    accepted_count++;
  endtask

  task automatic send_request(input io_bedrock_pkg::lce_req_header_s hdr,
                              input logic [`IO_DATA_WIDTH-1:0] data);
    logic accepted;
    accepted         = 1'b0;
    lce_req_header_i = hdr;
    lce_req_data_i   = data;
    lce_req_v_i      = 1'b1;
    while (!accepted) begin
      // ready comes from queue state, settled by mid-cycle
      @(negedge clk_i);
      accepted = lce_req_ready_and_o;
      next_cycle();
    end
    model_accept(hdr, data);
    lce_req_v_i = 1'b0;
  endtask

  // command side, a transfer is decided mid-cycle and happens at the next edge
  always @(negedge clk_i) begin
    if (arst_n_i && lce_cmd_v_o && lce_cmd_ready_and_i) begin
      if (exp_hdr_q.size() == 0) begin
        fail_run("a command came out with no request outstanding");
      end else begin
        check_cmd_header(lce_cmd_header_o, exp_hdr_q.pop_front());
        check_cmd_data(lce_cmd_data_o, exp_data_q.pop_front());
        rcvd_count++;
      end
    end
  end

  initial begin
    io_bedrock_pkg::lce_req_header_s hdr;
    logic [`IO_DATA_WIDTH-1:0]       data;
    logic [31:0]                     gap_rnd;
    seed                = 32'hc32a;
    accepted_count      = 0;
    rcvd_count          = 0;
    clk_i               = 1'b0;
    arst_n_i            = 1'b0;
    did_i               = DID;
    cce_id_i            = CCE_ID;
    lce_req_header_i    = '0;
    lce_req_data_i      = '0;
    lce_req_v_i         = 1'b0;
    lce_cmd_ready_and_i = 1'b0;
    for (int w = 0; w < `IO_REG_WORDS; w++) begin
      model_regs[w] = '0;
    end
    repeat (8) @(posedge clk_i);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk_i);
    check_flag("lce_cmd_v_o", lce_cmd_v_o, 1'b0);
    check_flag("lce_req_ready_and_o", lce_req_ready_and_o, 1'b1);
    next_cycle();
    for (int n = 0; n < N_REQ; n++) begin
      gap_rnd = $random(seed);
      if (gap_rnd[1:0] == 2'b00) begin
        next_cycle();
      end
      make_request(hdr, data);
      send_request(hdr, data);
    end
    while (rcvd_count < accepted_count) begin
      next_cycle();
    end
    // quiet period, a duplicate would show up here
    repeat (20) next_cycle();
    if (rcvd_count == N_REQ && accepted_count == N_REQ && exp_hdr_q.size() == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      $display("%0d commands received for %0d accepted requests", rcvd_count, accepted_count);
      $display("=== FAIL ===");
      $fatal(1, "command count mismatch");
    end
  end

  // watchdog
  initial begin
    #(N_REQ * CYC_PER_REQ * CLK_PERIOD_NS);
    $display("timeout with %0d of %0d commands received", rcvd_count, N_REQ);
    $display("=== FAIL ===");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: src.f
+incdir+hw
hw/io_bedrock_pkg.sv
hw/io_msg_fifo.sv
hw/io_reg_endpoint.sv
hw/io_cce.sv
hw/io_subsystem_top.sv
verification/tb_io_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it, and exits 0 only on a passing run
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_io_subsystem --Mdir "$OBJ" -o tb_io_subsystem -f src.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/tb_io_subsystem" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  echo "result: fail"
  exit 1
fi

if grep -qx "=== PASS ===" "$LOG"; then
  echo "result: pass"
  exit 0
fi
echo "result: fail"
exit 1
